// ==== src/rv_ex_params.svh ====
// execute slice parameters
`ifndef RV_EX_PARAMS_SVH
`define RV_EX_PARAMS_SVH

// data and address width
`define RV_XLEN 32

// pc held in the pipeline registers after reset
`define RV_RESET_PC 32'h4000_0000

`endif

// ==== src/rv_ex_pkg.sv ====
// execute slice types
`include "rv_ex_params.svh"

package rv_ex_pkg;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and,
        alu_pass_b,  // lui
        alu_pc_add   // auipc
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu
    } br_op_e;

    typedef enum logic [1:0] {mem_none, mem_read, mem_write} mem_op_e;

    typedef enum logic [1:0] {size_byte, size_half, size_word} mem_size_e;

    typedef enum logic {addr_pc, addr_alu} addr_sel_e;

    // operation as issued by decode
    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] rs1;
        logic [`RV_XLEN-1:0] rs2;
        logic [`RV_XLEN-1:0] imm;
        logic                b_imm;     // operand b is the immediate
        alu_op_e             alu_op;
        br_op_e              br_op;
        mem_op_e             mem_op;
        mem_size_e           mem_size;
        addr_sel_e           addr_sel;
        logic [4:0]          rd;
    } issue_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] alu_out;
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] rs2;       // raw store data
        logic                br_taken;
        mem_op_e             mem_op;
        mem_size_e           mem_size;
        logic [4:0]          rd;
    } exe_res_t;

    // data cache request
    typedef struct packed {
        logic                read;
        logic                write;
        logic [`RV_XLEN-1:0] addr;
        logic [`RV_XLEN-1:0] wdata;
        logic [3:0]          byte_en;
    } mem_req_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] result;
        logic [`RV_XLEN-1:0] pc;
        logic [4:0]          rd;
        logic                br_taken;
    } wb_ctrl_t;

endpackage

// ==== src/de_exe_reg.sv ====
// decode to execute pipeline register
`timescale 1ns/10ps
`include "rv_ex_params.svh"

module de_exe_reg (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall_i,
    input  logic              issue_valid_i,
    input  rv_ex_pkg::issue_t issue_i,
    output rv_ex_pkg::issue_t de_q_o,
    output logic              de_valid_o
);

    // valid bit, bubbles travel as a cleared valid
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            de_valid_o <= 1'b0;
        end else if (!stall_i) begin
            de_valid_o <= issue_valid_i;
        end
    end

    // operation itself, loaded on every open edge
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            de_q_o    <= '0;          // control fields decode to none
            de_q_o.pc <= `RV_RESET_PC;
        end else if (!stall_i) begin
            de_q_o <= issue_i;
        end
        // stalled: hold
    end

endmodule

// ==== src/exe_alu.sv ====
// execute stage datapath
`timescale 1ns/10ps
`include "rv_ex_params.svh"

module exe_alu (
    input  rv_ex_pkg::issue_t   de_q_i,
    output rv_ex_pkg::exe_res_t res_o,
    output logic [`RV_XLEN-1:0] addr_o
);
    import rv_ex_pkg::*;

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [4:0]          shamt;
    logic [`RV_XLEN-1:0] alu_out;
    logic                br_taken;

    assign op_a  = de_q_i.rs1;
    assign op_b  = de_q_i.b_imm ? de_q_i.imm : de_q_i.rs2;
    assign shamt = op_b[4:0];   // rv32 shifts use five bits

    always_comb begin
        case (de_q_i.alu_op)
            alu_add:    alu_out = op_a + op_b;
            alu_sub:    alu_out = op_a - op_b;
            alu_sll:    alu_out = op_a << shamt;
            alu_slt:    alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
            alu_sltu:   alu_out = {31'd0, op_a < op_b};
            alu_xor:    alu_out = op_a ^ op_b;
            alu_srl:    alu_out = op_a >> shamt;
            alu_sra:    alu_out = $unsigned($signed(op_a) >>> shamt);
            alu_or:     alu_out = op_a | op_b;
            alu_and:    alu_out = op_a & op_b;
            alu_pass_b: alu_out = de_q_i.imm;              // lui
            alu_pc_add: alu_out = de_q_i.pc + de_q_i.imm;  // auipc
            default:    alu_out = '0;
        endcase
    end

    // branch compare always works on rs1 and rs2
    always_comb begin
        case (de_q_i.br_op)
            br_eq:   br_taken = (de_q_i.rs1 == de_q_i.rs2);
            br_ne:   br_taken = (de_q_i.rs1 != de_q_i.rs2);
            br_lt:   br_taken = ($signed(de_q_i.rs1) < $signed(de_q_i.rs2));
            br_ge:   br_taken = ($signed(de_q_i.rs1) >= $signed(de_q_i.rs2));
            br_ltu:  br_taken = (de_q_i.rs1 < de_q_i.rs2);
            br_geu:  br_taken = (de_q_i.rs1 >= de_q_i.rs2);
            default: br_taken = 1'b0;
        endcase
    end

    // effective address for the data cache
    assign addr_o = (de_q_i.addr_sel == addr_alu) ? de_q_i.rs1 + de_q_i.imm
                                                  : de_q_i.pc;

    always_comb begin
        res_o          = '0;
        res_o.alu_out  = alu_out;
        res_o.pc       = de_q_i.pc;
        res_o.rs2      = de_q_i.rs2;
        res_o.br_taken = br_taken;
        res_o.mem_op   = de_q_i.mem_op;
        res_o.mem_size = de_q_i.mem_size;
        res_o.rd       = de_q_i.rd;
    end

endmodule

// ==== src/exe_mem_reg.sv ====
// execute to memory pipeline register
`timescale 1ns/10ps
`include "rv_ex_params.svh"

module exe_mem_reg (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall_i,
    input  logic                de_valid_i,
    input  rv_ex_pkg::exe_res_t res_i,
    input  logic [`RV_XLEN-1:0] addr_i,
    output rv_ex_pkg::wb_ctrl_t wb_o,
    output logic                wb_valid_o,
    output rv_ex_pkg::mem_req_t mem_req_o
);
    import rv_ex_pkg::*;

    logic [`RV_XLEN-1:0] lane_wdata;
    logic [3:0]          lane_be;
    logic                do_read;
    logic                do_write;

    logic                wb_valid_q;
    logic                br_taken_q;
    logic [`RV_XLEN-1:0] pc_q;
    logic                read_q;
    logic                write_q;
    logic [3:0]          be_q;
    logic [`RV_XLEN-1:0] result_q;
    logic [4:0]          rd_q;
    logic [`RV_XLEN-1:0] addr_q;
    logic [`RV_XLEN-1:0] wdata_q;

    // steer store data onto the byte lanes
    always_comb begin
        lane_wdata = res_i.rs2;   // word
        lane_be    = 4'b1111;
        case (res_i.mem_size)
            size_byte: begin
                lane_wdata = {4{res_i.rs2[7:0]}};
                lane_be    = 4'b0001 << addr_i[1:0];
            end
            size_half: begin
                lane_wdata = {2{res_i.rs2[15:0]}};
                lane_be    = addr_i[1] ? 4'b1100 : 4'b0011;
            end
            default: ;
        endcase
    end

    assign do_read  = de_valid_i && (res_i.mem_op == mem_read);
    assign do_write = de_valid_i && (res_i.mem_op == mem_write);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wb_valid_q <= 1'b0;
            br_taken_q <= 1'b0;
            pc_q       <= `RV_RESET_PC;
            read_q     <= 1'b0;
            write_q    <= 1'b0;   // low out of reset, no spurious store
            be_q       <= 4'b0000;
        end else if (!stall_i) begin
            wb_valid_q <= de_valid_i;
            br_taken_q <= res_i.br_taken;
            pc_q       <= res_i.pc;
            read_q     <= do_read;
            write_q    <= do_write;
            be_q       <= (do_read || do_write) ? lane_be : 4'b0000;
        end
    end

    // payload, loaded alongside the control bits
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            result_q <= res_i.alu_out;
            rd_q     <= res_i.rd;
            addr_q   <= addr_i;   // unregistered address, same edge as the stage
            wdata_q  <= lane_wdata;
        end
    end

    assign wb_valid_o = wb_valid_q;
    assign wb_o = '{result: result_q, pc: pc_q, rd: rd_q, br_taken: br_taken_q};
    assign mem_req_o = '{read: read_q, write: write_q, addr: addr_q,
                         wdata: wdata_q, byte_en: be_q};

endmodule

// ==== src/exe_slice_top.sv ====
// execute to memory slice top
`timescale 1ns/10ps
`include "rv_ex_params.svh"

module exe_slice_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall_i,
    input  logic                issue_valid_i,
    input  rv_ex_pkg::issue_t   issue_i,
    output rv_ex_pkg::wb_ctrl_t wb_o,
    output logic                wb_valid_o,
    output rv_ex_pkg::mem_req_t mem_req_o
);
    import rv_ex_pkg::*;

    issue_t              de_q;
    logic                de_valid;
    exe_res_t            exe_res;
    logic [`RV_XLEN-1:0] exe_addr;

    de_exe_reg u_de_exe_reg (
        .clk           (clk),
        .rst           (rst),
        .stall_i       (stall_i),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .de_q_o        (de_q),
        .de_valid_o    (de_valid)
    );

    exe_alu u_exe_alu (
        .de_q_i (de_q),
        .res_o  (exe_res),
        .addr_o (exe_addr)
    );

    exe_mem_reg u_exe_mem_reg (
        .clk        (clk),
        .rst        (rst),
        .stall_i    (stall_i),
        .de_valid_i (de_valid),
        .res_i      (exe_res),
        .addr_i     (exe_addr),
        .wb_o       (wb_o),
        .wb_valid_o (wb_valid_o),
        .mem_req_o  (mem_req_o)
    );

endmodule

// ==== dv/clk_rst_gen.sv ====
// testbench clock and reset
`timescale 1ns/10ps

module clk_rst_gen #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // released on a falling edge, clear of the sampling edge
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== dv/tb_exe_slice.sv ====
// execute slice testbench
`timescale 1ns/10ps
`include "rv_ex_params.svh"

module tb_exe_slice;
    import rv_ex_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int RST_CYCLES = 16;

    // one stimulus row with the values the model expects for it
    typedef struct packed {
        issue_t   op;
        logic     valid;
        logic     stall;
        wb_ctrl_t exp_wb;
        mem_req_t exp_req;
    } row_t;

    typedef struct packed {
        int row;
        int edge_no;   // open edges seen before sampling
    } pend_t;

    logic     clk;
    logic     rst;
    logic     stall;
    logic     issue_valid;
    issue_t   issue;
    wb_ctrl_t wb;
    logic     wb_valid;
    mem_req_t mem_req;

    row_t        stim_table[$];
    pend_t       exp_q[$];
    logic [31:0] rng = 32'd23083;
    int          open_edges = 0;
    logic        last_open = 1'b0;
    logic        built = 1'b0;
    int          checks = 0;
    int          errors = 0;
    logic        held_valid;
    wb_ctrl_t    held_wb;
    mem_req_t    held_req;

    clk_rst_gen #(.PERIOD_NS(CLK_PERIOD), .RST_CYCLES(RST_CYCLES)) u_clk_rst_gen (
        .clk (clk),
        .rst (rst)
    );

    exe_slice_top uut (
        .clk           (clk),
        .rst           (rst),
        .stall_i       (stall),
        .issue_valid_i (issue_valid),
        .issue_i       (issue),
        .wb_o          (wb),
        .wb_valid_o    (wb_valid),
        .mem_req_o     (mem_req)
    );

    function automatic logic [31:0] xorshift32();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // two's complement compare from the sign bits
    function automatic logic less_signed(logic [31:0] a, logic [31:0] b);
        return (a[31] != b[31]) ? a[31] : (a < b);
    endfunction

    function automatic wb_ctrl_t model_wb(issue_t op);
        wb_ctrl_t    w;
        logic [31:0] b;
        logic [4:0]  sh;
        w    = '0;
        b    = op.b_imm ? op.imm : op.rs2;
        sh   = b[4:0];
        w.pc = op.pc;
        w.rd = op.rd;
        case (op.alu_op)
            alu_add:    w.result = op.rs1 + b;
            alu_sub:    w.result = op.rs1 - b;
            alu_sll:    w.result = op.rs1 << sh;
            alu_slt:    w.result = {31'd0, less_signed(op.rs1, b)};
            alu_sltu:   w.result = {31'd0, op.rs1 < b};
            alu_xor:    w.result = op.rs1 ^ b;
            alu_srl:    w.result = op.rs1 >> sh;
            alu_sra:    w.result = (op.rs1 >> sh) | ({32{op.rs1[31]}} & ~(32'hffff_ffff >> sh));
            alu_or:     w.result = op.rs1 | b;
            alu_and:    w.result = op.rs1 & b;
            alu_pass_b: w.result = op.imm;
            alu_pc_add: w.result = op.pc + op.imm;
            default:    w.result = '0;
        endcase
        case (op.br_op)
            br_eq:   w.br_taken = (op.rs1 == op.rs2);
            br_ne:   w.br_taken = (op.rs1 != op.rs2);
            br_lt:   w.br_taken = less_signed(op.rs1, op.rs2);
            br_ge:   w.br_taken = !less_signed(op.rs1, op.rs2);
            br_ltu:  w.br_taken = (op.rs1 < op.rs2);
            br_geu:  w.br_taken = !(op.rs1 < op.rs2);
            default: w.br_taken = 1'b0;
        endcase
        return w;
    endfunction

    // byte lanes worked out one at a time
    function automatic mem_req_t model_req(issue_t op);
        mem_req_t   r;
        logic [1:0] offs;
        int         lane;
        r       = '0;
        r.addr  = (op.addr_sel == addr_alu) ? op.rs1 + op.imm : op.pc;
        offs    = r.addr[1:0];
        r.read  = (op.mem_op == mem_read);
        r.write = (op.mem_op == mem_write);
        for (lane = 0; lane < 4; lane++) begin
            case (op.mem_size)
                size_byte: begin
                    r.wdata[8*lane +: 8] = op.rs2[7:0];
                    r.byte_en[lane]      = (lane == offs);
                end
                size_half: begin
                    r.wdata[8*lane +: 8] = lane[0] ? op.rs2[15:8] : op.rs2[7:0];
                    r.byte_en[lane]      = (lane[1] == offs[1]);
                end
                default: begin
                    r.wdata[8*lane +: 8] = op.rs2[8*lane +: 8];
                    r.byte_en[lane]      = 1'b1;
                end
            endcase
        end
        if (!(r.read || r.write))
            r.byte_en = 4'b0000;
        return r;
    endfunction

    function automatic issue_t make_op(alu_op_e alu, logic [31:0] rs1, logic [31:0] rs2,
                                       logic [31:0] imm, logic b_imm);
        issue_t      op;
        logic [31:0] rnd;
        rnd         = xorshift32();
        op          = '0;
        op.pc       = {rnd[31:2], 2'b00};
        op.rd       = rnd[6:2];
        op.rs1      = rs1;
        op.rs2      = rs2;
        op.imm      = imm;
        op.b_imm    = b_imm;
        op.alu_op   = alu;
        op.addr_sel = addr_alu;
        return op;
    endfunction

    task automatic add_row(input issue_t op, input logic valid, input logic stall_row);
        stim_table.push_back('{op: op, valid: valid, stall: stall_row,
                               exp_wb: model_wb(op), exp_req: model_req(op)});
    endtask

    task automatic build_table();
        issue_t      op;
        logic [31:0] rnd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] br_a [3];
        logic [31:0] br_b [3];
        int          k;
        int          j;
        int          s;
        int          o;
        br_a = '{32'h8000_0000, 32'h0000_0005, 32'hffff_ffff};
        br_b = '{32'h7fff_ffff, 32'h0000_0005, 32'h0000_0001};
        add_row(make_op(alu_add, 32'h7fff_ffff, 32'd1, 32'd0, 1'b0), 1'b1, 1'b0);
        add_row(make_op(alu_sub, 32'd5, 32'd9, 32'd0, 1'b0), 1'b1, 1'b0);
        add_row(make_op(alu_sll, 32'h8000_0001, 32'd33, 32'd0, 1'b0), 1'b1, 1'b0);
        add_row(make_op(alu_slt, 32'hffff_fffe, 32'd3, 32'd0, 1'b0), 1'b1, 1'b0);
        add_row(make_op(alu_sltu, 32'hffff_fffe, 32'd3, 32'd0, 1'b0), 1'b1, 1'b0);
        add_row(make_op(alu_xor, 32'hdead_beef, 32'd0, 32'h0f0f_0f0f, 1'b1), 1'b1, 1'b0);
        add_row(make_op(alu_srl, 32'h8000_0000, 32'd31, 32'd0, 1'b0), 1'b1, 1'b0);
        add_row(make_op(alu_sra, 32'h8000_0000, 32'd0, 32'd4, 1'b1), 1'b1, 1'b0);
        add_row(make_op(alu_sra, 32'hf0f0_0000, 32'd36, 32'd0, 1'b0), 1'b1, 1'b0);
        add_row(make_op(alu_or, 32'h1200_0034, 32'h0056_7800, 32'd0, 1'b0), 1'b1, 1'b0);
        add_row(make_op(alu_and, 32'hffff_0000, 32'd0, 32'h00ff_ff00, 1'b1), 1'b1, 1'b0);
        add_row(make_op(alu_pass_b, 32'd7, 32'd0, 32'h1234_5000, 1'b1), 1'b1, 1'b0);  // lui
        add_row(make_op(alu_pc_add, 32'd7, 32'd0, 32'h0000_1000, 1'b1), 1'b1, 1'b0);  // auipc
        for (k = 1; k <= 6; k++) begin
            for (j = 0; j < 3; j++) begin
                op       = make_op(alu_sub, br_a[j], br_b[j], 32'd0, 1'b0);
                op.br_op = br_op_e'(k[2:0]);
                add_row(op, 1'b1, 1'b0);
            end
        end
        // loads and stores of every size at every offset
        for (k = 0; k < 2; k++) begin
            for (s = 0; s < 3; s++) begin
                for (o = 0; o < 4; o++) begin
                    rnd         = xorshift32();
                    b           = xorshift32();
                    op          = make_op(alu_add, {rnd[31:2], 2'b00}, b, 32'h20 + o, 1'b1);
                    op.mem_op   = k[0] ? mem_write : mem_read;
                    op.mem_size = mem_size_e'(s[1:0]);
                    add_row(op, 1'b1, 1'b0);
                end
            end
        end
        for (o = 0; o < 4; o++) begin
            b           = xorshift32();
            op          = make_op(alu_add, 32'h0000_1000, b, 32'h100, 1'b1);
            op.pc[1:0]  = o[1:0];
            op.addr_sel = addr_pc;
            op.mem_op   = o[0] ? mem_read : mem_write;
            op.mem_size = size_byte;
            add_row(op, 1'b1, 1'b0);
        end
        repeat (64) begin
            rnd         = xorshift32();
            a           = xorshift32();
            b           = xorshift32();
            c           = xorshift32();
            op          = make_op(alu_op_e'(rnd[3:0] % 4'd12), a, b, c, rnd[13]);
            op.br_op    = br_op_e'(rnd[6:4] % 3'd7);
            op.mem_op   = mem_op_e'(rnd[9:8] % 2'd3);
            op.mem_size = mem_size_e'(rnd[11:10] % 2'd3);
            op.addr_sel = addr_sel_e'(rnd[12]);
            add_row(op, rnd[15:14] != 2'b00, rnd[17:16] == 2'b00);
        end
        repeat (4) add_row(op, 1'b0, 1'b0);   // drain
    endtask

    // issue is left steady on stalled rows
    task automatic apply_row(input int idx);
        row_t r;
        r     = stim_table[idx];
        stall = r.stall;
        if (!r.stall) begin
            issue       = r.op;
            issue_valid = r.valid;
            if (r.valid)
                exp_q.push_back('{row: idx, edge_no: open_edges});
            open_edges++;
        end
        last_open = !r.stall;
    endtask

    // a stalled edge leaves every output where it was
    task automatic check_outputs();
        pend_t p;
        row_t  r;
        string tag;
        if (!last_open) begin
            check_value(wb_valid, held_valid, "stalled wb_valid");
            check_value(wb.result, held_wb.result, "stalled result");
            check_value(wb.pc, held_wb.pc, "stalled pc");
            check_value({wb.rd, wb.br_taken}, {held_wb.rd, held_wb.br_taken},
                        "stalled rd and br_taken");
            check_value(mem_req.addr, held_req.addr, "stalled addr");
            check_value({mem_req.read, mem_req.write, mem_req.byte_en},
                        {held_req.read, held_req.write, held_req.byte_en},
                        "stalled strobes and byte_en");
        end else if (!wb_valid) begin
            check_value(mem_req.read, 1'b0, "bubble read strobe");
            check_value(mem_req.write, 1'b0, "bubble write strobe");
            check_value(mem_req.byte_en, 4'b0000, "bubble byte_en");
        end else if (exp_q.size() == 0) begin
            $display("ERROR at %0t: output marked valid with no operation outstanding", $time);
            errors++;
        end else begin
            p   = exp_q.pop_front();
            r   = stim_table[p.row];
            tag = $sformatf("row %0d", p.row);
            check_value(open_edges - p.edge_no, 2, {tag, " open edges to output"});
            check_value(wb.result, r.exp_wb.result, {tag, " result"});
            check_value(wb.rd, r.exp_wb.rd, {tag, " rd"});
            check_value(wb.pc, r.exp_wb.pc, {tag, " pc"});
            check_value(wb.br_taken, r.exp_wb.br_taken, {tag, " br_taken"});
            check_value(mem_req.read, r.exp_req.read, {tag, " read strobe"});
            check_value(mem_req.write, r.exp_req.write, {tag, " write strobe"});
            check_value(mem_req.byte_en, r.exp_req.byte_en, {tag, " byte_en"});
            if (r.exp_req.read || r.exp_req.write)
                check_value(mem_req.addr, r.exp_req.addr, {tag, " addr"});
            if (r.exp_req.write)
                check_value(mem_req.wdata, r.exp_req.wdata, {tag, " wdata"});
        end
        held_valid = wb_valid;
        held_wb    = wb;
        held_req   = mem_req;
    endtask

    initial begin
        stall       = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        build_table();
        built = 1'b1;
        @(negedge rst);
        check_value(wb_valid, 1'b0, "reset wb_valid");
        check_value(mem_req.read, 1'b0, "reset read strobe");
        check_value(mem_req.write, 1'b0, "reset write strobe");
        check_value(mem_req.byte_en, 4'b0000, "reset byte_en");
        check_value(wb.pc, `RV_RESET_PC, "reset pc");
        last_open = 1'b1;
        foreach (stim_table[i]) begin
            @(negedge clk);
            check_outputs();
            apply_row(i);
        end
        @(negedge clk);
        check_outputs();
        if (exp_q.size() != 0) begin
            $display("ERROR: %0d operations never reached the outputs", exp_q.size());
            errors++;
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    // watchdog sized from the table
    initial begin
        wait (built);
        #((stim_table.size() * 20 + RST_CYCLES) * CLK_PERIOD);
        $display("ERROR: timeout, the run did not finish in the expected time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+src
src/rv_ex_pkg.sv
src/de_exe_reg.sv
src/exe_alu.sv
src/exe_mem_reg.sv
src/exe_slice_top.sv
dv/clk_rst_gen.sv
dv/tb_exe_slice.sv

// ==== Bender.yml ====
package:
  name: rv_exe_slice

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/rv_ex_pkg.sv
      - src/de_exe_reg.sv
      - src/exe_alu.sv
      - src/exe_mem_reg.sv
      - src/exe_slice_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/clk_rst_gen.sv
      - dv/tb_exe_slice.sv
